// ==== klara_plic.f ====
+incdir+common
+incdir+test
common/plic_pkg.sv
common/plic_reg_if.sv
plic/plic_arbiter.sv
plic/plic_gateway.sv
plic/plic_ctrl.sv
hdl/plic_top.sv
test/tb_plic.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the PLIC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f klara_plic.f \
	--top-module tb_plic \
	-Mdir obj_dir

sim_output=$(./obj_dir/Vtb_plic || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1

// ==== test/tb_plic_table.svh ====
`ifndef TB_PLIC_TABLE_SVH
`define TB_PLIC_TABLE_SVH

localparam int NUM_ROWS = 30;

stim_row_t stim_rows [NUM_ROWS];

task automatic load_table();
	// Columns: op, address, wdata, sources {4,3,2,1}, global enable, rdata, pulses
	stim_rows[0]  = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b0000, 1'b0, 32'h00, 4'd0};
	stim_rows[1]  = '{OP_READ,  `PLIC_ADDR_ENABLE,  32'h00, 4'b0000, 1'b0, 32'h00, 4'd0};
	stim_rows[2]  = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b0000, 1'b0, 32'h00, 4'd0};
	// Enable sources 2 and 4, source 1 stays disabled
	stim_rows[3]  = '{OP_WRITE, `PLIC_ADDR_ENABLE,  32'h14, 4'b0000, 1'b0, 32'h00, 4'd0};
	stim_rows[4]  = '{OP_READ,  `PLIC_ADDR_ENABLE,  32'h00, 4'b0000, 1'b0, 32'h14, 4'd0};
	stim_rows[5]  = '{OP_IDLE,  24'h000000,         32'h00, 4'b0001, 1'b1, 32'h00, 4'd0};
	stim_rows[6]  = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b0001, 1'b1, 32'h00, 4'd0};
	// Sources 2 and 4 active while the global enable is low
	stim_rows[7]  = '{OP_IDLE,  24'h000000,         32'h00, 4'b1010, 1'b0, 32'h00, 4'd0};
	stim_rows[8]  = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b0, 32'h00, 4'd0};
	stim_rows[9]  = '{OP_IDLE,  24'h000000,         32'h00, 4'b1010, 1'b1, 32'h00, 4'd1};
	stim_rows[10] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b1, 32'h0A, 4'd0};
	// Claims in fixed priority order
	stim_rows[11] = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b1010, 1'b1, 32'h02, 4'd0};
	stim_rows[12] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b1, 32'h08, 4'd0};
	stim_rows[13] = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b1010, 1'b1, 32'h04, 4'd0};
	stim_rows[14] = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b1010, 1'b1, 32'h00, 4'd0};
	stim_rows[15] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b1, 32'h00, 4'd0};
	// Complete releases the held source, it pends again
	stim_rows[16] = '{OP_WRITE, `PLIC_ADDR_CLAIM,   32'h02, 4'b1010, 1'b1, 32'h00, 4'd1};
	stim_rows[17] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b1, 32'h02, 4'd0};
	stim_rows[18] = '{OP_WRITE, `PLIC_ADDR_CLAIM,   32'h04, 4'b1010, 1'b1, 32'h00, 4'd1};
	stim_rows[19] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b1, 32'h0A, 4'd0};
	stim_rows[20] = '{OP_IDLE,  24'h000000,         32'h00, 4'b1010, 1'b1, 32'h00, 4'd0};
	stim_rows[21] = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b1010, 1'b1, 32'h02, 4'd0};
	stim_rows[22] = '{OP_WRITE, `PLIC_ADDR_CLAIM,   32'h02, 4'b1010, 1'b1, 32'h00, 4'd1};
	stim_rows[23] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b1010, 1'b1, 32'h0A, 4'd0};
	// Sources drop, latched requests drain
	stim_rows[24] = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b0000, 1'b1, 32'h02, 4'd0};
	stim_rows[25] = '{OP_READ,  `PLIC_ADDR_CLAIM,   32'h00, 4'b0000, 1'b1, 32'h04, 4'd0};
	stim_rows[26] = '{OP_WRITE, `PLIC_ADDR_CLAIM,   32'h02, 4'b0000, 1'b1, 32'h00, 4'd0};
	stim_rows[27] = '{OP_WRITE, `PLIC_ADDR_CLAIM,   32'h04, 4'b0000, 1'b1, 32'h00, 4'd0};
	stim_rows[28] = '{OP_READ,  `PLIC_ADDR_PENDING, 32'h00, 4'b0000, 1'b1, 32'h00, 4'd0};
	stim_rows[29] = '{OP_READ,  `PLIC_ADDR_ENABLE,  32'h00, 4'b0000, 1'b1, 32'h14, 4'd0};
endtask

`endif

// ==== test/tb_plic.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module tb_plic;
	import plic_pkg::*;

	localparam logic [1:0] OP_IDLE  = 2'd0;
	localparam logic [1:0] OP_READ  = 2'd1;
	localparam logic [1:0] OP_WRITE = 2'd2;

	typedef struct packed {
		logic [1:0] op;
		addr_t      address;
		data_t      wdata;
		src_mask_t  sources;        // Bit 0 is source 1
		logic       global_enable;
		data_t      exp_rdata;
		logic [3:0] exp_pulses;     // Pulses seen within the row window
	} stim_row_t;

	`include "tb_plic_table.svh"

	localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 50;

	logic  i_clock;
	logic  i_reset;
	logic  i_interrupt_0;
	logic  i_interrupt_1;
	logic  i_interrupt_2;
	logic  i_interrupt_3;
	logic  i_interrupt_enable;
	logic  i_request;
	logic  i_rw;
	addr_t i_address;
	data_t i_wdata;
	data_t o_rdata;
	logic  o_ready;
	logic  o_interrupt;

	int error_count = 0;
	int rows_failed = 0;
	int cycle_count = 0;
	int pulse_count = 0;

	plic_top u_dut (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_interrupt_0      (i_interrupt_0),
		.i_interrupt_1      (i_interrupt_1),
		.i_interrupt_2      (i_interrupt_2),
		.i_interrupt_3      (i_interrupt_3),
		.i_interrupt_enable (i_interrupt_enable),
		.o_interrupt        (o_interrupt),
		.i_request          (i_request),
		.i_rw               (i_rw),
		.i_address          (i_address),
		.i_wdata            (i_wdata),
		.o_rdata            (o_rdata),
		.o_ready            (o_ready)
	);

	initial i_clock = 1'b0;
	always #4 i_clock = ~i_clock;  // 8 ns period

	always @(posedge i_clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			error_count++;
		end
	endtask

	function automatic string op_name(input logic [1:0] op);
		case (op)
			OP_READ:  return "read ";
			OP_WRITE: return "write";
			default:  return "idle ";
		endcase
	endfunction

	task automatic drive_inputs(input stim_row_t row);
		i_request          = (row.op != OP_IDLE);
		i_rw               = (row.op == OP_WRITE);
		i_address          = row.address;
		i_wdata            = row.wdata;
		i_interrupt_enable = row.global_enable;
		{i_interrupt_3, i_interrupt_2, i_interrupt_1, i_interrupt_0} = row.sources;
	endtask

	// Apply one row over a request cycle and two idle cycles
	task automatic run_row(input int index);
		stim_row_t row;
		int        errors_before;
		string     verdict;
		row           = stim_rows[index];
		errors_before = error_count;
		pulse_count   = 0;
		drive_inputs(row);
		@(negedge i_clock);
		if (o_interrupt) pulse_count++;
		if (row.op == OP_IDLE) begin
			check_value("o_ready", 32'(o_ready), 32'h0);
		end
		else if (o_ready !== 1'b1) begin
			$display("Row %0d: no ready response in the cycle after the request", index);
			error_count++;
		end
		check_value("o_rdata", o_rdata, row.exp_rdata);
		i_request = 1'b0;
		i_rw      = 1'b0;
		i_address = '0;
		i_wdata   = '0;
		repeat (2) begin
			@(negedge i_clock);
			if (o_interrupt) pulse_count++;
			check_value("o_ready", 32'(o_ready), 32'h0);
			check_value("o_rdata", o_rdata, 32'h0);
		end
		check_value("o_interrupt pulses", 32'(pulse_count), 32'(row.exp_pulses));
		if (error_count != errors_before) begin
			rows_failed++;
			verdict = "mismatch";
		end
		else begin
			verdict = "ok";
		end
		$display("Row %2d %s 0x%06h: %s", index, op_name(row.op), row.address, verdict);
	endtask

	initial begin
		i_reset            = 1'b1;
		i_interrupt_0      = 1'b0;
		i_interrupt_1      = 1'b0;
		i_interrupt_2      = 1'b0;
		i_interrupt_3      = 1'b0;
		i_interrupt_enable = 1'b0;
		i_request          = 1'b0;
		i_rw               = 1'b0;
		i_address          = '0;
		i_wdata            = '0;
		load_table();

		repeat (3) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(i);
		end

		$display("Rows run: %0d, rows failed: %0d, failed checks: %0d",
			NUM_ROWS, rows_failed, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/plic_top.sv ====
`timescale 1ns/1ps

module plic_top (
	input  logic            i_clock,
	input  logic            i_reset,

	// Interrupt sources, level sensitive
	input  logic            i_interrupt_0,
	input  logic            i_interrupt_1,
	input  logic            i_interrupt_2,
	input  logic            i_interrupt_3,

	// Notification to the CPU
	input  logic            i_interrupt_enable,
	output logic            o_interrupt,

	// CPU port
	input  logic            i_request,
	input  logic            i_rw,
	input  plic_pkg::addr_t i_address,
	input  plic_pkg::data_t i_wdata,
	output plic_pkg::data_t o_rdata,
	output logic            o_ready
);
	import plic_pkg::*;

	src_mask_t sources;

	assign sources = {i_interrupt_3, i_interrupt_2, i_interrupt_1, i_interrupt_0};

	plic_reg_if reg_bus ();

	plic_ctrl u_ctrl (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_request          (i_request),
		.i_rw               (i_rw),
		.i_address          (i_address),
		.i_wdata            (i_wdata),
		.i_interrupt_enable (i_interrupt_enable),
		.o_rdata            (o_rdata),
		.o_ready            (o_ready),
		.o_interrupt        (o_interrupt),
		.reg_bus            (reg_bus.ctrl)
	);

	plic_gateway u_gateway (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_sources          (sources),
		.i_interrupt_enable (i_interrupt_enable),
		.reg_bus            (reg_bus.gateway)
	);

	plic_arbiter u_arbiter (
		.reg_bus (reg_bus.arbiter)
	);

endmodule

// ==== plic/plic_ctrl.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_ctrl (
	input  logic            i_clock,
	input  logic            i_reset,
	input  logic            i_request,
	input  logic            i_rw,
	input  plic_pkg::addr_t i_address,
	input  plic_pkg::data_t i_wdata,
	input  logic            i_interrupt_enable,
	output plic_pkg::data_t o_rdata,
	output logic            o_ready,
	output logic            o_interrupt,
	plic_reg_if.ctrl        reg_bus
);
	import plic_pkg::*;

	logic          is_read;
	logic          is_write;
	logic          hit_pending;
	logic          hit_enable;
	logic          hit_claim;
	data_t         read_data;
	notify_state_t state;
	notify_state_t state_next;

	assign is_read  = i_request && !i_rw;
	assign is_write = i_request && i_rw;

	assign hit_pending = (i_address == `PLIC_ADDR_PENDING);
	assign hit_enable  = (i_address == `PLIC_ADDR_ENABLE);
	assign hit_claim   = (i_address == `PLIC_ADDR_CLAIM);

	// Strobes are live in the request cycle itself
	assign reg_bus.enable_we    = is_write && hit_enable;
	assign reg_bus.enable_wdata = i_wdata[`PLIC_SOURCES:1];  // Bit n+1 enables source n
	assign reg_bus.claim_re     = is_read && hit_claim;
	assign reg_bus.complete_we  = is_write && hit_claim;
	assign reg_bus.complete_id  = i_wdata[$bits(src_id_t)-1:0];

	// Unmapped addresses read as 0
	always_comb begin
		read_data = '0;
		if (hit_pending) begin
			read_data = data_t'(reg_bus.pending);
		end
		else if (hit_enable) begin
			read_data = data_t'({reg_bus.enable, 1'b0});
		end
		else if (hit_claim) begin
			read_data = data_t'(reg_bus.claim_id);
		end
	end

	// Every request is answered on the next cycle
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
		end
		else begin
			o_ready <= i_request;
			o_rdata <= is_read ? read_data : '0;  // Zero outside the ready cycle
		end
	end

	// Notification FSM
	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (i_interrupt_enable && (|reg_bus.pending)) begin
					state_next = issued;
				end
			end
			issued: begin
				// A fast CPU may complete right in the pulse cycle
				state_next = reg_bus.complete_we ? idle : wait_complete;
			end
			wait_complete: begin
				if (reg_bus.complete_we) begin
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= idle;
		end
		else begin
			state <= state_next;
		end
	end

	assign o_interrupt = (state == issued);  // One cycle per round

	a_ready_follows_request: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_request |=> o_ready
	) else $error("o_ready missing one cycle after i_request");

	a_interrupt_single_pulse: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_interrupt |=> !o_interrupt
	) else $error("o_interrupt high for two cycles in a row");

endmodule

// ==== plic/plic_gateway.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_gateway (
	input  logic               i_clock,
	input  logic               i_reset,
	input  plic_pkg::src_mask_t i_sources,
	input  logic               i_interrupt_enable,
	plic_reg_if.gateway        reg_bus
);
	import plic_pkg::*;

	src_mask_t enable;
	src_mask_t pending;
	src_mask_t in_service;
	src_mask_t claim_mask;     // Source taken by this cycle's claim
	src_mask_t complete_mask;  // Source released by this cycle's complete
	src_mask_t set_mask;

	// Decode the claimed and completed IDs into source bits
	always_comb begin
		claim_mask    = '0;
		complete_mask = '0;
		for (int i = 0; i < `PLIC_SOURCES; i++) begin
			claim_mask[i] = reg_bus.claim_re &&
				(reg_bus.claim_id == src_id_t'(i + 1));
			complete_mask[i] = reg_bus.complete_we &&
				(reg_bus.complete_id == src_id_t'(i + 1));
		end
	end

	// Level sources latch into pending only while not already in service
	assign set_mask = i_sources & enable & ~in_service & {`PLIC_SOURCES{i_interrupt_enable}};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			enable <= '0;
		end
		else if (reg_bus.enable_we) begin
			enable <= reg_bus.enable_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pending    <= '0;
			in_service <= '0;
		end
		else begin
			// Claim wins over a new request from the same source
			pending    <= (pending | set_mask) & ~claim_mask;
			in_service <= (in_service | claim_mask) & ~complete_mask;
		end
	end

	assign reg_bus.enable  = enable;
	assign reg_bus.pending = pending;

	a_pending_not_in_service: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(pending & in_service) == '0
	) else $error("source both pending and in service");

endmodule

// ==== plic/plic_arbiter.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_arbiter (
	plic_reg_if.arbiter reg_bus
);
	import plic_pkg::*;

	src_id_t winner;

	// Lowest pending source wins
	always_comb begin
		winner = '0;
		for (int i = `PLIC_SOURCES - 1; i >= 0; i--) begin
			if (reg_bus.pending[i]) begin
				winner = src_id_t'(i + 1);  // IDs start at 1
			end
		end
	end

	assign reg_bus.claim_id = winner;

endmodule

// ==== common/plic_reg_if.sv ====
`timescale 1ns/1ps

interface plic_reg_if;
	import plic_pkg::*;

	logic      enable_we;     // Write strobe for the enable register
	src_mask_t enable_wdata;
	logic      claim_re;      // Claim read, moves a source to in-service
	logic      complete_we;   // Complete write
	src_id_t   complete_id;

	// Returned by the datapath
	src_mask_t enable;
	src_mask_t pending;
	src_id_t   claim_id;

	modport ctrl (
		output enable_we, enable_wdata, claim_re, complete_we, complete_id,
		input  enable, pending, claim_id
	);

	modport gateway (
		input  enable_we, enable_wdata, claim_re, complete_we, complete_id, claim_id,
		output enable, pending
	);

	modport arbiter (
		input  pending,
		output claim_id
	);

endinterface

// ==== common/plic_pkg.sv ====
`include "plic_params.svh"

package plic_pkg;

	// One bit per source, bit n is source n+1 on the bus
	typedef logic [`PLIC_SOURCES-1:0] src_mask_t;

	// Source ID as seen by the CPU, 0 means nothing pending
	typedef logic [2:0] src_id_t;

	typedef logic [`PLIC_ADDR_W-1:0] addr_t;
	typedef logic [`PLIC_DATA_W-1:0] data_t;

	// Notification to the CPU, one pulse per claim/complete round
	typedef enum logic [1:0] {
		idle,          // Nothing outstanding
		issued,        // Pulse cycle
		wait_complete  // Waiting for the CPU to complete
	} notify_state_t;

endpackage

// ==== common/plic_params.svh ====
`ifndef PLIC_PARAMS_SVH
`define PLIC_PARAMS_SVH

// Interrupt sources handled by the controller
`define PLIC_SOURCES 4

// CPU port widths
`define PLIC_ADDR_W 24
`define PLIC_DATA_W 32

// Register map, context 0 only
`define PLIC_ADDR_PENDING 24'h001000
`define PLIC_ADDR_ENABLE  24'h002000
`define PLIC_ADDR_CLAIM   24'h200004

`endif
